//--- dv/tb_clk_gen.sv
module tb_clk_gen
(
    output logic    o_clk,
    output logic    o_arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        o_clk    = 1'b0;
        o_arst_n = 1'b0;
        repeat (4) @(posedge o_clk);
        #1 o_arst_n = 1'b1;                    // Released off the edge.
    end

    always #2 o_clk = ~o_clk;                  // 4 ns period.

endmodule

//--- dv/tb_rv_mem_subsys.sv
module tb_rv_mem_subsys;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_mem_pkg::*;

    typedef struct
    {
        logic [4:0]     rd;
        logic           reg_write;
        logic [31:0]    data;
        int             due;
    } exp_t;

    logic           i_clk;
    logic           i_arst_n;
    ex_mem_t        i_ex;
    axil_s2m_t      i_axil;
    logic           o_ready;
    wb_t            o_wb;
    axil_m2s_t      o_axil;

    exp_t           exp_q[$];
    exp_t           head;
    logic           head_ok;
    logic [3:0]     exp_wstrb;
    logic [31:0]    tcm_sh[DTCM_WORDS];
    logic [31:0]    bus_sh[16];
    logic [31:0]    slv_mem[16];
    logic [31:0]    rng = 32'h1406;
    int             cyc;
    int             n_issued;
    int             n_checked;
    int             n_err;

    tb_clk_gen u_clk_gen (.o_clk(i_clk), .o_arst_n(i_arst_n));

    rv_mem_subsys u_dut
    (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_ex       (i_ex),
        .i_axil     (i_axil),
        .o_ready    (o_ready),
        .o_wb       (o_wb),
        .o_axil     (o_axil)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [3:0] lane_sel(logic [2:0] f3, logic [1:0] off);
        int         size;
        logic [3:0] sel;
        size = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
        for (int b = 0; b < 4; b++)
            sel[b] = (b >= off) && (b < off + size);   // Lanes off up to off+size-1.
        return sel;
    endfunction

    function automatic logic [31:0] merge_store(logic [31:0] old, logic [31:0] val,
                                                logic [2:0] f3, logic [1:0] off);
        logic [31:0] res;
        logic [3:0]  sel;
        res = old;
        sel = lane_sel(f3, off);
        for (int b = 0; b < 4; b++)
            if (sel[b])
                res[8*b +: 8] = val[8*(b - off) +: 8];  // Lane b takes byte b-off of rs2.
        return res;
    endfunction

    function automatic logic [31:0] load_ext(logic [31:0] word, logic [2:0] f3,
                                             logic [1:0] off);
        logic [7:0]  byt;
        logic [15:0] half;
        byt  = word[8*off +: 8];
        half = off[1] ? word[31:16] : word[15:0];
        case (f3)
            F3_B:    return {{24{byt[7]}}, byt};
            F3_BU:   return {24'h0, byt};
            F3_H:    return {{16{half[15]}}, half};
            F3_HU:   return {16'h0, half};
            default: return word;
        endcase
    endfunction

    // Issue one item, wait for acceptance and record what it should produce.
    task automatic issue(input ex_mem_t it);
        exp_t        e;
        logic        rdy;
        int          acc;
        logic        tcm;
        logic [1:0]  off;
        logic [31:0] word;
        i_ex = it;
        do
        begin
            @(negedge i_clk);
            rdy = o_ready;
            acc = cyc;
            @(posedge i_clk);
            #1;
        end
        while (!rdy);
        i_ex = '0;
        n_issued++;
        tcm  = (it.alu_result[31:28] == DTCM_SEL);
        off  = it.alu_result[1:0];
        word = tcm ? tcm_sh[it.alu_result[9:2]] : bus_sh[it.alu_result[5:2]];
        e.rd = it.rd;
        e.reg_write = it.reg_write;
        e.due = acc + 2;
        if (it.mem_write)
        begin
            if (tcm)
                tcm_sh[it.alu_result[9:2]] = merge_store(word, it.rs2_val, it.funct3, off);
            else
            begin
                bus_sh[it.alu_result[5:2]] = merge_store(word, it.rs2_val, it.funct3, off);
                exp_wstrb = lane_sel(it.funct3, off);
            end
            return;
        end
        if (it.mem_read)
        begin
            e.data = load_ext(word, it.funct3, off);
            if (!tcm)
                e.due = 0;                     // Bus latency is not fixed.
        end
        else if (it.res_src == RES_PC4)
            e.data = {it.pc_p4, 2'b00};
        else
            e.data = it.alu_result;
        exp_q.push_back(e);
    endtask

    function automatic ex_mem_t make_item(int kind, logic [31:0] addr, logic [2:0] f3);
        ex_mem_t it;
        it = '0;
        it.valid      = 1'b1;
        it.alu_result = addr;
        it.rs2_val    = next_rand();
        it.rd         = next_rand() % 32;
        it.reg_write  = (kind != 3);
        it.funct3     = f3;
        it.pc_p4      = next_rand();
        it.res_src    = (kind == 1) ? RES_PC4 : (kind == 2) ? RES_BUS : RES_ALU;
        it.mem_read   = (kind == 2);
        it.mem_write  = (kind == 3);
        return it;
    endfunction

    function automatic logic [31:0] rand_addr(logic bus, logic [2:0] f3);
        logic [31:0] a;
        a = bus ? 32'h4000_0000 : 32'h0000_0000;
        a[5:2] = next_rand();
        if (f3[1:0] == 2'b00)
            a[1:0] = next_rand();
        else if (f3[1:0] == 2'b01)
            a[1] = next_rand();
        return a;
    endfunction

    function automatic logic [2:0] rand_f3(logic store);
        logic [2:0] tab[5] = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};
        return store ? tab[next_rand() % 3] : tab[next_rand() % 5];
    endfunction

    always @(posedge i_clk)
    begin
        cyc <= cyc + 1;
        if (cyc > 40 * n_issued + 100)
        begin
            $display("Timeout: the writeback stream stopped making progress");
            $display("Simulation failed");
            $finish;
        end
    end

    // Each writeback takes its expected record off the queue.
    always @(negedge i_clk)
    begin
        if (i_arst_n && o_wb.valid)
        begin
            head_ok = (exp_q.size() > 0);
            if (head_ok)
            begin
                head = exp_q.pop_front();
                n_checked++;
            end
        end
    end

    a_wb_expected: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_wb.valid |-> head_ok)
    else
    begin
        n_err++;
        $display("Writeback appeared with nothing expected");
    end

    a_wb_rd: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_wb.valid && head_ok |-> o_wb.rd == head.rd)
    else
    begin
        n_err++;
        $display("Error o_wb.rd expected %h got %h", head.rd, $sampled(o_wb.rd));
    end

    a_wb_data: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_wb.valid && head_ok |-> o_wb.data == head.data)
    else
    begin
        n_err++;
        $display("Error o_wb.data expected %h got %h", head.data, $sampled(o_wb.data));
    end

    a_wb_rw: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_wb.valid && head_ok |-> o_wb.reg_write == head.reg_write)
    else
    begin
        n_err++;
        $display("Error o_wb.reg_write expected %h got %h",
                 head.reg_write, $sampled(o_wb.reg_write));
    end

    a_wb_time: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_wb.valid && head_ok && head.due != 0 |-> cyc == head.due)
    else
    begin
        n_err++;
        $display("Writeback arrived at cycle %0d, not at cycle %0d",
                 $sampled(cyc), head.due);
    end

    a_wstrb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_axil.wvalid |-> o_axil.wstrb == exp_wstrb)
    else
    begin
        n_err++;
        $display("Error o_axil.wstrb expected %h got %h",
                 $sampled(exp_wstrb), $sampled(o_axil.wstrb));
    end

    // AXI4-Lite slave; fire flags mark handshakes due at the next edge.
    initial
    begin
        logic aw_fire, w_fire, ar_fire, b_fire, r_fire, aw_got, w_got, b_pend, r_pend;
        logic [31:0] aw_addr, w_data, ar_addr;
        logic [3:0]  w_strb;
        int aw_dly, w_dly, ar_dly, b_dly, r_dly;
        {aw_fire, w_fire, ar_fire, b_fire, r_fire, aw_got, w_got, b_pend, r_pend} = '0;
        aw_dly = next_rand() % 4;
        w_dly  = next_rand() % 4;
        ar_dly = next_rand() % 4;
        wait (i_arst_n);
        forever
        begin
            @(posedge i_clk);
            #1;
            if (aw_fire)
            begin
                i_axil.awready = 0;
                aw_got = 1;
                aw_dly = next_rand() % 4;
            end
            if (w_fire)
            begin
                i_axil.wready = 0;
                w_got = 1;
                w_dly = next_rand() % 4;
            end
            if (ar_fire)
            begin
                i_axil.arready = 0;
                r_pend = 1;
                r_dly  = next_rand() % 4;
                ar_dly = next_rand() % 4;
            end
            if (b_fire)
                i_axil.bvalid = 0;
            if (r_fire)
                i_axil.rvalid = 0;
            if (aw_got && w_got)
            begin
                for (int b = 0; b < 4; b++)
                    if (w_strb[b])
                        slv_mem[aw_addr[5:2]][8*b +: 8] = w_data[8*b +: 8];
                {aw_got, w_got, b_pend} = 3'b001;
                b_dly = next_rand() % 4;
            end
            if (o_axil.awvalid && !aw_got && !i_axil.awready)
            begin
                if (aw_dly == 0)
                    i_axil.awready = 1;
                else
                    aw_dly--;
            end
            if (o_axil.wvalid && !w_got && !i_axil.wready)
            begin
                if (w_dly == 0)
                    i_axil.wready = 1;
                else
                    w_dly--;
            end
            if (o_axil.arvalid && !r_pend && !i_axil.arready)
            begin
                if (ar_dly == 0)
                    i_axil.arready = 1;
                else
                    ar_dly--;
            end
            if (b_pend)
            begin
                if (b_dly == 0)
                begin
                    i_axil.bvalid = 1;
                    b_pend = 0;
                end
                else
                    b_dly--;
            end
            if (r_pend)
            begin
                if (r_dly == 0)
                begin
                    i_axil.rvalid = 1;
                    i_axil.rdata  = slv_mem[ar_addr[5:2]];
                    r_pend = 0;
                end
                else
                    r_dly--;
            end
            aw_fire = i_axil.awready && o_axil.awvalid;
            w_fire  = i_axil.wready && o_axil.wvalid;
            ar_fire = i_axil.arready && o_axil.arvalid;
            b_fire  = i_axil.bvalid && o_axil.bready;
            r_fire  = i_axil.rvalid && o_axil.rready;
            if (aw_fire)
                aw_addr = o_axil.awaddr;
            if (w_fire)
            begin
                w_data = o_axil.wdata;
                w_strb = o_axil.wstrb;
            end
            if (ar_fire)
                ar_addr = o_axil.araddr;
        end
    end

    task automatic finish_test(input string name);
        int limit;
        limit = cyc + 200;
        while (exp_q.size() > 0 && cyc < limit)
            @(posedge i_clk);
        repeat (3) @(posedge i_clk);
        #1;
        $display("Test %s finished, %0d errors so far", name, n_err);
    endtask

    initial
    begin
        int kind;
        logic bus;
        logic [2:0] f3;
        i_ex = '0;
        i_axil = '0;
        {n_issued, n_checked, n_err, exp_wstrb} = '0;
        head_ok = 0;
        for (int a = 0; a < 16; a++)
        begin
            slv_mem[a] = 32'h4000_0000 ^ (a * 32'h0101_0107);   // Differs per word.
            bus_sh[a]  = slv_mem[a];
        end
        wait (i_arst_n);
        @(posedge i_clk);
        #1;
        assert (!o_wb.valid && !o_axil.awvalid && !o_axil.wvalid && !o_axil.arvalid
                && !o_axil.bready && !o_axil.rready && o_ready)
        else
        begin
            n_err++;
            $display("Outputs after reset are not in their idle state");
        end
        $display("Test reset finished, %0d errors so far", n_err);

        for (int k = 0; k < 8; k++)
            issue(make_item(k % 2, next_rand(), F3_W));
        finish_test("alu_pc4");

        for (int a = 0; a < 16; a++)
            issue(make_item(3, a * 4, F3_W));
        for (int o = 0; o < 4; o++)
            issue(make_item(3, 32'h10 + o, F3_B));
        for (int o = 0; o < 4; o += 2)
            issue(make_item(3, 32'h20 + o, F3_H));
        for (int o = 0; o < 4; o++)
        begin
            issue(make_item(2, 32'h10 + o, F3_B));
            issue(make_item(2, 32'h10 + o, F3_BU));
            if (o[0] == 0)
            begin
                issue(make_item(2, 32'h20 + o, F3_H));
                issue(make_item(2, 32'h20 + o, F3_HU));
            end
        end
        issue(make_item(2, 32'h30, F3_W));
        finish_test("dtcm");

        for (int k = 0; k < 24; k++)
        begin
            kind = (k % 2) ? 2 : 3;
            issue(make_item(kind, 32'h4000_0000, F3_W));
        end
        finish_test("bus_warmup");

        for (int k = 0; k < 24; k++)
        begin
            kind = (k % 2) ? 2 : 3;
            f3   = rand_f3(kind == 3);
            issue(make_item(kind, rand_addr(1, f3), f3));
        end
        finish_test("bus_fixed");

        for (int k = 0; k < 200; k++)
        begin
            kind = next_rand() % 4;
            bus  = next_rand();
            if (kind >= 2)
            begin
                ex_mem_t it;
                it = make_item(kind, 0, rand_f3(kind == 3));
                it.alu_result = rand_addr(bus, it.funct3);
                issue(it);
            end
            else
                issue(make_item(kind, next_rand(), F3_W));
            repeat (next_rand() % 3)
            begin
                @(posedge i_clk);
                #1;
            end
        end
        finish_test("mixed_stream");

        $display("Checked %0d writebacks, %0d issued, %0d errors, %0d missing",
                 n_checked, n_issued, n_err, exp_q.size());
        if (n_err == 0 && exp_q.size() == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- hdl/rv_axil_dbus.sv
module rv_axil_dbus
(
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_start,
    input  logic                    i_write,
    input  logic [31:0]             i_addr,
    input  logic [3:0]              i_sel,
    input  logic [31:0]             i_wdata,
    input  rv_mem_pkg::axil_s2m_t   i_axil,
    output rv_mem_pkg::axil_m2s_t   o_axil,
    output logic                    o_done,
    output logic [31:0]             o_rdata
);
    import rv_mem_pkg::*;

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_ADDR,
        S_RESP,
        S_DONE
    } state_e;

    state_e         r_state;
    logic           r_write;
    logic           r_awvalid;
    logic           r_wvalid;
    logic           r_arvalid;
    logic           r_bready;
    logic           r_rready;
    logic [31:0]    r_addr;
    logic [31:0]    r_wdata;
    logic [3:0]     r_sel;
    logic           w_aw_ok;
    logic           w_w_ok;

    assign w_aw_ok = ~r_awvalid | i_axil.awready;
    assign w_w_ok  = ~r_wvalid  | i_axil.wready;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_state   <= S_IDLE;
            r_write   <= 1'b0;
            r_awvalid <= 1'b0;
            r_wvalid  <= 1'b0;
            r_arvalid <= 1'b0;
            r_bready  <= 1'b0;
            r_rready  <= 1'b0;
        end
        else
        begin
            case (r_state)
                S_IDLE:
                begin
                    if (i_start)
                    begin
                        r_write   <= i_write;
                        r_awvalid <= i_write;
                        r_wvalid  <= i_write;
                        r_arvalid <= ~i_write;
                        r_state   <= S_ADDR;
                    end
                end
                S_ADDR:
                begin
                    if (i_axil.awready)
                        r_awvalid <= 1'b0;
                    if (i_axil.wready)
                        r_wvalid <= 1'b0;
                    if (i_axil.arready)
                        r_arvalid <= 1'b0;
                    if (r_write && w_aw_ok && w_w_ok)
                    begin
                        r_bready <= 1'b1;       // Both channels accepted.
                        r_state  <= S_RESP;
                    end
                    else if (!r_write && i_axil.arready)
                    begin
                        r_rready <= 1'b1;
                        r_state  <= S_RESP;
                    end
                end
                S_RESP:
                begin
                    if ((r_bready && i_axil.bvalid) || (r_rready && i_axil.rvalid))
                    begin
                        r_bready <= 1'b0;
                        r_rready <= 1'b0;
                        r_state  <= S_DONE;
                    end
                end
                default:
                    r_state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start && r_state == S_IDLE)
        begin
            r_addr  <= i_addr;
            r_wdata <= i_wdata;
            r_sel   <= i_sel;
        end
        if (r_rready && i_axil.rvalid)
            o_rdata <= i_axil.rdata;    // Load data kept for the done cycle.
    end

    assign o_done = (r_state == S_DONE);

    always_comb
    begin
        o_axil.awvalid = r_awvalid;
        o_axil.awaddr  = r_addr;
        o_axil.wvalid  = r_wvalid;
        o_axil.wdata   = r_wdata;
        o_axil.wstrb   = r_sel;
        o_axil.bready  = r_bready;
        o_axil.arvalid = r_arvalid;
        o_axil.araddr  = r_addr;
        o_axil.rready  = r_rready;
    end

    a_aw_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_axil.awvalid && !i_axil.awready |=> o_axil.awvalid && $stable(o_axil.awaddr));

    a_w_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_axil.wvalid && !i_axil.wready |=> o_axil.wvalid && $stable(o_axil.wdata)
        && $stable(o_axil.wstrb));

    a_ar_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_axil.arvalid && !i_axil.arready |=> o_axil.arvalid && $stable(o_axil.araddr));

    a_start_idle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_start |-> r_state == S_IDLE);

    // Error responses are not recovered from.
    a_resp_okay: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (r_bready && i_axil.bvalid && i_axil.bresp != 2'b00)
        || (r_rready && i_axil.rvalid && i_axil.rresp != 2'b00) |-> 1'b0);

endmodule

//--- hdl/rv_dtcm.sv
module rv_dtcm
(
    input  logic                            i_clk,
    input  logic                            i_en,
    input  logic                            i_we,
    input  logic [rv_mem_pkg::DTCM_AW-1:0]  i_addr,
    input  logic [3:0]                      i_sel,
    input  logic [31:0]                     i_wdata,
    output logic [31:0]                     o_rdata
);
    import rv_mem_pkg::*;

    logic [31:0] mem [DTCM_WORDS];

    always_ff @(posedge i_clk)
    begin
        if (i_en)
        begin
            if (i_we)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (i_sel[b])
                        mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];    // Byte lane write.
                end
            end
            else
            begin
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

//--- hdl/rv_mem_pkg.sv
package rv_mem_pkg;

    // Address map, bits 31:28 pick the slave.
    localparam int          DTCM_SEL_HI = 31;
    localparam int          DTCM_SEL_LO = 28;
    localparam logic [3:0]  DTCM_SEL    = 4'h0;
    localparam int          DTCM_WORDS  = 256;
    localparam int          DTCM_AW     = 8;

    typedef enum logic [1:0]
    {
        RES_ALU = 2'd0,
        RES_BUS = 2'd1,
        RES_PC4 = 2'd2,
        RES_TCM = 2'd3
    } res_src_e;

    localparam logic [2:0]  F3_B  = 3'b000;
    localparam logic [2:0]  F3_H  = 3'b001;
    localparam logic [2:0]  F3_W  = 3'b010;
    localparam logic [2:0]  F3_BU = 3'b100;
    localparam logic [2:0]  F3_HU = 3'b101;

    typedef struct packed
    {
        logic           valid;
        logic [31:0]    alu_result;
        logic [31:0]    rs2_val;
        logic [4:0]     rd;
        logic           reg_write;
        logic           mem_read;
        logic           mem_write;
        res_src_e       res_src;
        logic [2:0]     funct3;
        logic [31:2]    pc_p4;
    } ex_mem_t;

    typedef struct packed
    {
        logic           valid;
        logic [31:0]    alu_result;
        logic [4:0]     rd;
        logic           reg_write;
        res_src_e       res_src;
        logic [2:0]     funct3;
        logic [31:2]    pc_p4;
        logic [31:0]    bus_rdata;
    } mem_wb_t;

    typedef struct packed
    {
        logic           valid;
        logic           reg_write;
        logic [4:0]     rd;
        logic [31:0]    data;
    } wb_t;

    typedef struct packed
    {
        logic           awvalid;
        logic [31:0]    awaddr;
        logic           wvalid;
        logic [31:0]    wdata;
        logic [3:0]     wstrb;
        logic           bready;
        logic           arvalid;
        logic [31:0]    araddr;
        logic           rready;
    } axil_m2s_t;

    typedef struct packed
    {
        logic           awready;
        logic           wready;
        logic           bvalid;
        logic [1:0]     bresp;
        logic           arready;
        logic           rvalid;
        logic [31:0]    rdata;
        logic [1:0]     rresp;
    } axil_s2m_t;

endpackage

//--- hdl/rv_mem_subsys.sv
module rv_mem_subsys
(
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  rv_mem_pkg::ex_mem_t     i_ex,
    input  rv_mem_pkg::axil_s2m_t   i_axil,
    output logic                    o_ready,
    output rv_mem_pkg::wb_t         o_wb,
    output rv_mem_pkg::axil_m2s_t   o_axil
);
    import rv_mem_pkg::*;

    mem_wb_t                w_mw;
    logic                   w_tcm_en;
    logic                   w_tcm_we;
    logic [DTCM_AW-1:0]     w_tcm_addr;
    logic [3:0]             w_tcm_sel;
    logic [31:0]            w_tcm_wdata;
    logic [31:0]            w_tcm_rdata;
    logic                   w_bus_start;
    logic                   w_bus_write;
    logic [31:0]            w_bus_addr;
    logic [3:0]             w_bus_sel;
    logic [31:0]            w_bus_wdata;
    logic                   w_bus_done;
    logic [31:0]            w_bus_rdata;

    rv_memory u_memory
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_ex           (i_ex),
        .i_bus_done     (w_bus_done),
        .i_bus_rdata    (w_bus_rdata),
        .o_ready        (o_ready),
        .o_mw           (w_mw),
        .o_tcm_en       (w_tcm_en),
        .o_tcm_we       (w_tcm_we),
        .o_tcm_addr     (w_tcm_addr),
        .o_tcm_sel      (w_tcm_sel),
        .o_tcm_wdata    (w_tcm_wdata),
        .o_bus_start    (w_bus_start),
        .o_bus_write    (w_bus_write),
        .o_bus_addr     (w_bus_addr),
        .o_bus_sel      (w_bus_sel),
        .o_bus_wdata    (w_bus_wdata)
    );

    rv_dtcm u_dtcm
    (
        .i_clk          (i_clk),
        .i_en           (w_tcm_en),
        .i_we           (w_tcm_we),
        .i_addr         (w_tcm_addr),
        .i_sel          (w_tcm_sel),
        .i_wdata        (w_tcm_wdata),
        .o_rdata        (w_tcm_rdata)
    );

    rv_axil_dbus u_dbus
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_start        (w_bus_start),
        .i_write        (w_bus_write),
        .i_addr         (w_bus_addr),
        .i_sel          (w_bus_sel),
        .i_wdata        (w_bus_wdata),
        .i_axil         (i_axil),
        .o_axil         (o_axil),
        .o_done         (w_bus_done),
        .o_rdata        (w_bus_rdata)
    );

    rv_writeback u_wb
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_mw           (w_mw),
        .i_tcm_rdata    (w_tcm_rdata),
        .o_wb           (o_wb)
    );

endmodule

//--- hdl/rv_memory.sv
module rv_memory
(
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  rv_mem_pkg::ex_mem_t             i_ex,
    input  logic                            i_bus_done,
    input  logic [31:0]                     i_bus_rdata,
    output logic                            o_ready,
    output rv_mem_pkg::mem_wb_t             o_mw,
    output logic                            o_tcm_en,
    output logic                            o_tcm_we,
    output logic [rv_mem_pkg::DTCM_AW-1:0]  o_tcm_addr,
    output logic [3:0]                      o_tcm_sel,
    output logic [31:0]                     o_tcm_wdata,
    output logic                            o_bus_start,
    output logic                            o_bus_write,
    output logic [31:0]                     o_bus_addr,
    output logic [3:0]                      o_bus_sel,
    output logic [31:0]                     o_bus_wdata
);
    import rv_mem_pkg::*;

    ex_mem_t        r_ex;
    logic           r_bus_pend;
    logic           w_is_tcm;
    logic           w_mem_acc;
    logic           w_bus_acc;
    logic [3:0]     w_sel;
    logic [31:0]    w_wdata;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            r_ex <= '0;
        else if (o_ready)
            r_ex <= i_ex;
    end

    assign w_is_tcm  = (r_ex.alu_result[DTCM_SEL_HI:DTCM_SEL_LO] == DTCM_SEL);
    assign w_mem_acc = r_ex.valid & (r_ex.mem_read | r_ex.mem_write);
    assign w_bus_acc = w_mem_acc & ~w_is_tcm;
    assign o_ready   = ~w_bus_acc | i_bus_done;        // Hold until the bus finishes.

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            r_bus_pend <= 1'b0;
        else if (o_bus_start)
            r_bus_pend <= 1'b1;
        else if (i_bus_done)
            r_bus_pend <= 1'b0;
    end

    always_comb
    begin
        case (r_ex.funct3[1:0])
            2'b00:   w_wdata = {4{r_ex.rs2_val[7:0]}};
            2'b01:   w_wdata = {2{r_ex.rs2_val[15:0]}};
            default: w_wdata = r_ex.rs2_val;
        endcase
    end

    always_comb
    begin
        case (r_ex.funct3[1:0])
            2'b00:   w_sel = 4'b0001 << r_ex.alu_result[1:0];
            2'b01:   w_sel = r_ex.alu_result[1] ? 4'b1100 : 4'b0011;
            default: w_sel = 4'b1111;
        endcase
    end

    assign o_tcm_en    = w_mem_acc & w_is_tcm;
    assign o_tcm_we    = r_ex.mem_write;
    assign o_tcm_addr  = r_ex.alu_result[DTCM_AW+1:2];
    assign o_tcm_sel   = w_sel;
    assign o_tcm_wdata = w_wdata;

    assign o_bus_start = w_bus_acc & ~r_bus_pend;       // One pulse per access.
    assign o_bus_write = r_ex.mem_write;
    assign o_bus_addr  = r_ex.alu_result;
    assign o_bus_sel   = w_sel;
    assign o_bus_wdata = w_wdata;

    always_comb
    begin
        o_mw.valid      = r_ex.valid & o_ready & ~r_ex.mem_write;   // Stores end here.
        o_mw.alu_result = r_ex.alu_result;
        o_mw.rd         = r_ex.rd;
        o_mw.reg_write  = r_ex.reg_write;
        o_mw.res_src    = (r_ex.mem_read & w_is_tcm) ? RES_TCM : r_ex.res_src;
        o_mw.funct3     = r_ex.funct3;
        o_mw.pc_p4      = r_ex.pc_p4;
        o_mw.bus_rdata  = i_bus_rdata;
    end

    a_ex_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_ex.valid && !o_ready |=> $stable(i_ex));

    a_done_pending: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_bus_done |-> w_bus_acc && r_bus_pend);

endmodule

//--- hdl/rv_writeback.sv
module rv_writeback
(
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  rv_mem_pkg::mem_wb_t     i_mw,
    input  logic [31:0]             i_tcm_rdata,
    output rv_mem_pkg::wb_t         o_wb
);
    import rv_mem_pkg::*;

    mem_wb_t        r_mw;
    logic [31:0]    w_raw;
    logic [31:0]    w_shift;
    logic           w_load;
    logic [31:0]    w_data;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            r_mw <= '0;
        else
            r_mw <= i_mw;
    end

    always_comb
    begin
        case (r_mw.res_src)
            RES_ALU: w_raw = r_mw.alu_result;
            RES_BUS: w_raw = r_mw.bus_rdata;
            RES_PC4: w_raw = {r_mw.pc_p4, 2'b00};
            default: w_raw = i_tcm_rdata;       // DTCM word from last cycle.
        endcase
    end

    assign w_load  = (r_mw.res_src == RES_BUS) || (r_mw.res_src == RES_TCM);
    assign w_shift = w_raw >> {r_mw.alu_result[1:0], 3'b000};

    always_comb
    begin
        if (!w_load)
            w_data = w_raw;
        else
        begin
            case (r_mw.funct3)
                F3_B:    w_data = {{24{w_shift[7]}}, w_shift[7:0]};
                F3_BU:   w_data = {24'h0, w_shift[7:0]};
                F3_H:    w_data = {{16{w_shift[15]}}, w_shift[15:0]};
                F3_HU:   w_data = {16'h0, w_shift[15:0]};
                F3_W:    w_data = w_raw;
                default: w_data = w_raw;
            endcase
        end
    end

    always_comb
    begin
        o_wb.valid     = r_mw.valid;
        o_wb.reg_write = r_mw.reg_write;
        o_wb.rd        = r_mw.rd;
        o_wb.data      = w_data;
    end

endmodule

//--- project.f
hdl/rv_mem_pkg.sv
hdl/rv_memory.sv
hdl/rv_dtcm.sv
hdl/rv_axil_dbus.sv
hdl/rv_writeback.sv
hdl/rv_mem_subsys.sv
dv/tb_clk_gen.sv
dv/tb_rv_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_rv_mem_subsys -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation passed$" sim.log && exit 0 || { echo "Run failed, see logs"; exit 1; }
